// ==== design/isa_pkg.sv ====
package isa_pkg;

	typedef logic [31:0] xlen_t;
	typedef logic [4:0]  reg_idx_t;

	// RV32I major opcodes kept by this core
	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LUI    = 7'b0110111,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011
	} opcode_e;

	typedef enum logic [3:0] {
		ADD, SUB, AND, OR, XOR, SLT, SLL, SRL, PASS_B
	} alu_op_e;

	// Instruction formats, all 32 bits
	typedef struct packed {
		logic [6:0] funct7;
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		logic [2:0] funct3;
		reg_idx_t   rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		reg_idx_t    rs1;
		logic [2:0]  funct3;
		reg_idx_t    rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;	// imm[11:5]
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;	// imm[4:0]
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic [19:0] imm;	// imm[31:12]
		reg_idx_t    rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		u_fmt_t u;
	} inst_u;

	// Control bundle, all zero is a no-op
	typedef struct packed {
		alu_op_e alu_op;
		logic    use_imm;	// Operand B from immediate
		logic    reg_write;
		logic    mem_read;
		logic    mem_write;
		logic    uses_rs1;	// For load-use detection
		logic    uses_rs2;
	} ctrl_t;

	typedef struct packed {
		ctrl_t    ctrl;
		reg_idx_t rs1;
		reg_idx_t rs2;
		xlen_t    rs1_val;
		xlen_t    rs2_val;
		reg_idx_t rd;
		xlen_t    imm;
	} id_ex_t;

	typedef struct packed {
		ctrl_t    ctrl;
		reg_idx_t rd;
		xlen_t    alu_res;
		xlen_t    store_data;
	} ex_mem_t;

	typedef struct packed {
		logic     reg_write;
		reg_idx_t rd;
		xlen_t    wdata;
	} mem_wb_t;

endpackage

// ==== design/soc_bus_pkg.sv ====
package soc_bus_pkg;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [11:0] paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic        pready;
		logic        pslverr;
		logic [31:0] prdata;
	} apb_rsp_t;

	// Outside write into IMEM or DMEM, idx is a word index
	typedef struct packed {
		logic        imem_we;
		logic        dmem_we;
		logic [7:0]  idx;
		logic [31:0] wdata;
	} mem_acc_t;

	// Register offsets
	localparam logic [11:0] CTRL_OFFS     = 12'h000;
	localparam logic [11:0] PROG_LEN_OFFS = 12'h004;
	localparam logic [11:0] STATUS_OFFS   = 12'h008;

	// Memory windows, 1 KB each
	localparam logic [11:0] IMEM_BASE = 12'h400;
	localparam logic [11:0] DMEM_BASE = 12'h800;
	localparam logic [11:0] WIN_SIZE  = 12'h400;

endpackage

// ==== design/ctrl_regs.sv ====
`timescale 1ns/1ps

module ctrl_regs
	import isa_pkg::*;
	import soc_bus_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  apb_req_t   apb_req,
	input  xlen_t      dmem_rdata,
	input  logic       done,
	output apb_rsp_t   apb_rsp,
	output logic       start,
	output logic [7:0] prog_len,
	output mem_acc_t   imem_acc,
	output mem_acc_t   dmem_acc
);

	logic        access;	// APB access phase
	logic        hit_ctrl, hit_len, hit_status;
	logic        in_imem, in_dmem;
	logic        win_busy, err, wr_ok, go;
	logic        running, run_done;
	logic [7:0]  win_idx;	// Word within a window

	//////////////////////////////////////////////////////////////////////
	// Address decode

	assign access     = apb_req.psel & apb_req.penable;
	assign hit_ctrl   = apb_req.paddr == CTRL_OFFS;
	assign hit_len    = apb_req.paddr == PROG_LEN_OFFS;
	assign hit_status = apb_req.paddr == STATUS_OFFS;
	assign in_imem    = (apb_req.paddr >= IMEM_BASE) && (apb_req.paddr < IMEM_BASE + WIN_SIZE);
	assign in_dmem    = (apb_req.paddr >= DMEM_BASE) && (apb_req.paddr < DMEM_BASE + WIN_SIZE);

	// No window writes while the core owns the memories
	assign win_busy = (in_imem | in_dmem) & apb_req.pwrite & running;
	assign err      = access & (~(in_imem | in_dmem | hit_ctrl | hit_len | hit_status) | win_busy);
	assign wr_ok    = access & apb_req.pwrite & ~err;
	assign go       = wr_ok & hit_ctrl & apb_req.pwdata[0] & ~running;	// Ignored mid-run

	// Windows are 1 KB aligned so the base drops out of the index
	assign win_idx = apb_req.paddr[9:2];

	//////////////////////////////////////////////////////////////////////
	// Control and status

	always_ff @(posedge clk) begin
		if (reset) begin
			start    <= 1'b0;
			running  <= 1'b0;
			run_done <= 1'b0;
			prog_len <= '0;
		end else begin
			start <= go;	// Single-cycle pulse
			if (wr_ok & hit_len)
				prog_len <= apb_req.pwdata[7:0];
			if (go) begin
				running  <= 1'b1;
				run_done <= 1'b0;
			end else if (done) begin
				running  <= 1'b0;
				run_done <= 1'b1;	// Sticky until next start
			end
		end
	end

	// Same window index also serves DMEM reads
	always_comb begin
		imem_acc = '{imem_we: wr_ok & in_imem, dmem_we: 1'b0,
			idx: win_idx, wdata: apb_req.pwdata};
		dmem_acc = '{imem_we: 1'b0, dmem_we: wr_ok & in_dmem,
			idx: win_idx, wdata: apb_req.pwdata};
	end

	// Read mux with a write-only IMEM window
	always_comb begin
		apb_rsp.pready  = 1'b1;	// Never waits
		apb_rsp.pslverr = err;
		apb_rsp.prdata  = '0;
		if (hit_len)
			apb_rsp.prdata = {24'b0, prog_len};
		else if (hit_status)
			apb_rsp.prdata = {30'b0, run_done, running};
		else if (in_dmem)
			apb_rsp.prdata = dmem_rdata;
	end

endmodule

// ==== design/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder
	import isa_pkg::*;
(
	input  inst_u    inst,
	output reg_idx_t rs1,
	output reg_idx_t rs2,
	output reg_idx_t rd,
	output xlen_t    imm,
	output ctrl_t    ctrl
);

	xlen_t imm_i, imm_s;

	assign imm_i = {{20{inst.i.imm[11]}}, inst.i.imm};	// Sign extended
	assign imm_s = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};

	always_comb begin
		rs1  = inst.r.rs1;	// Register fields sit at fixed bits
		rs2  = inst.r.rs2;
		rd   = inst.r.rd;
		imm  = '0;
		ctrl = '0;
		case (inst.r.opcode)
			OP: begin
				ctrl.reg_write = 1'b1;
				ctrl.uses_rs1  = 1'b1;
				ctrl.uses_rs2  = 1'b1;
				case (inst.r.funct3)
					3'b000:  ctrl.alu_op = inst.r.funct7[5] ? SUB : ADD;
					3'b001:  ctrl.alu_op = SLL;
					3'b010:  ctrl.alu_op = SLT;
					3'b100:  ctrl.alu_op = XOR;
					3'b101:  ctrl.alu_op = SRL;
					3'b110:  ctrl.alu_op = OR;
					3'b111:  ctrl.alu_op = AND;
					default: ctrl = '0;	// SLTU
				endcase
				if (inst.r.funct3 == 3'b101 && inst.r.funct7[5])
					ctrl = '0;	// SRA not supported
			end
			OP_IMM: begin
				imm            = imm_i;
				ctrl.use_imm   = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.uses_rs1  = 1'b1;
				case (inst.i.funct3)
					3'b000:  ctrl.alu_op = ADD;
					3'b010:  ctrl.alu_op = SLT;
					3'b100:  ctrl.alu_op = XOR;
					3'b110:  ctrl.alu_op = OR;
					3'b111:  ctrl.alu_op = AND;
					default: ctrl = '0;	// Immediate shifts, SLTIU
				endcase
			end
			LUI: begin
				imm            = {inst.u.imm, 12'b0};
				ctrl.alu_op    = PASS_B;
				ctrl.use_imm   = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			LOAD: if (inst.i.funct3 == 3'b010) begin	// LW only
				imm            = imm_i;
				ctrl.alu_op    = ADD;
				ctrl.use_imm   = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.mem_read  = 1'b1;
				ctrl.uses_rs1  = 1'b1;
			end
			STORE: if (inst.s.funct3 == 3'b010) begin	// SW only
				imm            = imm_s;
				ctrl.alu_op    = ADD;
				ctrl.use_imm   = 1'b1;
				ctrl.mem_write = 1'b1;
				ctrl.uses_rs1  = 1'b1;
				ctrl.uses_rs2  = 1'b1;
			end
			default: ;	// Unknown opcode retires as no-op
		endcase
		if (rd == '0)
			ctrl.reg_write = 1'b0;	// x0 never written or forwarded
	end

endmodule

// ==== design/core_pipeline.sv ====
`timescale 1ns/1ps

module core_pipeline
	import isa_pkg::*;
	import soc_bus_pkg::*;
#(
	parameter int IMEM_WORDS = 256
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       start,
	input  logic [7:0] prog_len,
	input  mem_acc_t   imem_acc,
	input  xlen_t      dmem_rdata,
	output logic [7:0] dmem_addr,
	output logic       dmem_we,
	output xlen_t      dmem_wdata,
	output logic       done
);

	xlen_t      imem [IMEM_WORDS];
	xlen_t      rf [32];
	logic [7:0] pc;	// Word index
	logic       active, fetch_fire, load_use;
	logic       id_valid, ex_valid, mem_valid, wb_valid;	// Real instruction per stage
	logic [2:0] in_flight;
	inst_u      if_id_inst;
	reg_idx_t   rs1_d, rs2_d, rd_d;
	xlen_t      imm_d;
	ctrl_t      ctrl_d;
	id_ex_t     id_ex;
	ex_mem_t    ex_mem;
	mem_wb_t    mem_wb;
	xlen_t      op_a, op_b, rs2_fwd, alu_res, mem_result;

	// Register read sees this cycle's write-back
	function automatic xlen_t rf_read(reg_idx_t idx);
		if (mem_wb.reg_write && mem_wb.rd == idx)
			return mem_wb.wdata;
		return rf[idx];
	endfunction

	// MEM stage wins over WB
	function automatic xlen_t fwd(reg_idx_t idx, xlen_t val);
		if (ex_mem.ctrl.reg_write && ex_mem.rd == idx)
			return mem_result;
		if (mem_wb.reg_write && mem_wb.rd == idx)
			return mem_wb.wdata;
		return val;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Fetch and hazard control

	assign load_use = id_ex.ctrl.mem_read && id_ex.ctrl.reg_write &&
		((ctrl_d.uses_rs1 && rs1_d == id_ex.rd) || (ctrl_d.uses_rs2 && rs2_d == id_ex.rd));
	assign fetch_fire = active && (pc < prog_len) && !load_use;
	assign done       = active && (pc == prog_len) && (in_flight == 3'(wb_valid));

	always_ff @(posedge clk)
		if (imem_acc.imem_we)
			imem[imem_acc.idx] <= imem_acc.wdata;	// Loaded over APB

	inst_decoder decoder_inst (
		.inst (if_id_inst),
		.rs1  (rs1_d),
		.rs2  (rs2_d),
		.rd   (rd_d),
		.imm  (imm_d),
		.ctrl (ctrl_d)
	);

	//////////////////////////////////////////////////////////////////////
	// Execute and memory

	always_comb begin
		op_a    = fwd(id_ex.rs1, id_ex.rs1_val);
		rs2_fwd = fwd(id_ex.rs2, id_ex.rs2_val);	// Also the store data
		op_b    = id_ex.ctrl.use_imm ? id_ex.imm : rs2_fwd;
		case (id_ex.ctrl.alu_op)
			ADD:     alu_res = op_a + op_b;
			SUB:     alu_res = op_a - op_b;
			AND:     alu_res = op_a & op_b;
			OR:      alu_res = op_a | op_b;
			XOR:     alu_res = op_a ^ op_b;
			SLT:     alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
			SLL:     alu_res = op_a << op_b[4:0];
			SRL:     alu_res = op_a >> op_b[4:0];
			PASS_B:  alu_res = op_b;	// LUI
			default: alu_res = '0;
		endcase
	end

	assign dmem_addr  = ex_mem.alu_res[9:2];
	assign dmem_we    = ex_mem.ctrl.mem_write;
	assign dmem_wdata = ex_mem.store_data;
	assign mem_result = ex_mem.ctrl.mem_read ? dmem_rdata : ex_mem.alu_res;

	//////////////////////////////////////////////////////////////////////
	// Stage registers

	always_ff @(posedge clk) begin
		if (reset) begin
			active     <= 1'b0;
			pc         <= '0;
			in_flight  <= '0;
			id_valid   <= 1'b0;
			ex_valid   <= 1'b0;
			mem_valid  <= 1'b0;
			wb_valid   <= 1'b0;
			if_id_inst <= '0;
			id_ex      <= '0;
			ex_mem     <= '0;
			mem_wb     <= '0;
		end else begin
			if (start) begin
				active <= 1'b1;
				pc     <= '0;
			end else if (done)
				active <= 1'b0;
			else if (fetch_fire)
				pc <= pc + 8'd1;
			in_flight <= in_flight + 3'(fetch_fire) - 3'(wb_valid);
			if (!load_use) begin	// Freeze IF/ID on load-use
				if_id_inst <= fetch_fire ? imem[pc] : '0;	// Past prog_len feed no-ops
				id_valid   <= fetch_fire;
				id_ex      <= '{ctrl: ctrl_d, rs1: rs1_d, rs2: rs2_d,
					rs1_val: rf_read(rs1_d), rs2_val: rf_read(rs2_d), rd: rd_d, imm: imm_d};
				ex_valid   <= id_valid;
			end else begin
				id_ex    <= '0;	// Bubble
				ex_valid <= 1'b0;
			end
			ex_mem    <= '{ctrl: id_ex.ctrl, rd: id_ex.rd, alu_res: alu_res, store_data: rs2_fwd};
			mem_valid <= ex_valid;
			mem_wb    <= '{reg_write: ex_mem.ctrl.reg_write, rd: ex_mem.rd, wdata: mem_result};
			wb_valid  <= mem_valid;
		end
	end

	// Register file, x0 is never written
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				rf[i] <= '0;
		end else if (mem_wb.reg_write)
			rf[mem_wb.rd] <= mem_wb.wdata;
	end

endmodule

// ==== design/data_mem.sv ====
`timescale 1ns/1ps

module data_mem
	import isa_pkg::*;
	import soc_bus_pkg::*;
#(
	parameter int DMEM_WORDS = 256
) (
	input  logic       clk,
	input  logic [7:0] core_addr,	// Word index
	input  logic       core_we,
	input  xlen_t      core_wdata,
	input  mem_acc_t   ext_acc,
	output xlen_t      core_rdata,
	output xlen_t      ext_rdata
);

	xlen_t mem [DMEM_WORDS];

	// Outside writes only happen while the core is idle
	always_ff @(posedge clk) begin
		if (core_we)
			mem[core_addr] <= core_wdata;
		else if (ext_acc.dmem_we)
			mem[ext_acc.idx] <= ext_acc.wdata;
	end

	// Combinational read on both ports
	assign core_rdata = mem[core_addr];
	assign ext_rdata  = mem[ext_acc.idx];

endmodule

// ==== design/core_top.sv ====
`timescale 1ns/1ps

module core_top
	import isa_pkg::*;
	import soc_bus_pkg::*;
#(
	parameter int IMEM_WORDS = 256,
	parameter int DMEM_WORDS = 256
) (
	input  logic     clk,
	input  logic     reset,
	input  apb_req_t apb_req,
	output apb_rsp_t apb_rsp
);

	logic       start, done;
	logic [7:0] prog_len;
	logic [7:0] dmem_addr;	// Core port word index
	logic       dmem_we;
	xlen_t      dmem_wdata, core_rdata, ext_rdata;
	mem_acc_t   imem_acc, dmem_acc;

	ctrl_regs ctrl_regs_inst (
		.clk        (clk),
		.reset      (reset),
		.apb_req    (apb_req),
		.dmem_rdata (ext_rdata),
		.done       (done),
		.apb_rsp    (apb_rsp),
		.start      (start),
		.prog_len   (prog_len),
		.imem_acc   (imem_acc),
		.dmem_acc   (dmem_acc)
	);

	core_pipeline #(.IMEM_WORDS(IMEM_WORDS)) core_pipeline_inst (
		.clk        (clk),
		.reset      (reset),
		.start      (start),
		.prog_len   (prog_len),
		.imem_acc   (imem_acc),
		.dmem_rdata (core_rdata),
		.dmem_addr  (dmem_addr),
		.dmem_we    (dmem_we),
		.dmem_wdata (dmem_wdata),
		.done       (done)
	);

	data_mem #(.DMEM_WORDS(DMEM_WORDS)) data_mem_inst (
		.clk        (clk),
		.core_addr  (dmem_addr),
		.core_we    (dmem_we),
		.core_wdata (dmem_wdata),
		.ext_acc    (dmem_acc),
		.core_rdata (core_rdata),
		.ext_rdata  (ext_rdata)
	);

endmodule

// ==== verif/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen #(
	parameter int PERIOD       = 40,	// ns
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Sync reset, released on a rising edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

// ==== verif/core_sva.sv ====
`timescale 1ns/1ps

module core_sva
	import soc_bus_pkg::*;
(
	input logic     clk,
	input logic     reset,
	input apb_req_t apb_req,
	input logic     start
);

	// Access phase only inside a selected transfer
	penable_with_psel: assert property (@(posedge clk) disable iff (reset)
		apb_req.penable |-> apb_req.psel)
		else $error("penable high without psel");

	// Run start is a single-cycle pulse
	single_start: assert property (@(posedge clk) disable iff (reset)
		start |=> !start)
		else $error("start high for two cycles in a row");

endmodule

bind ctrl_regs core_sva core_sva_inst (
	.clk     (clk),
	.reset   (reset),
	.apb_req (apb_req),
	.start   (start)
);

// ==== verif/core_tb.sv ====
`timescale 1ns/1ps

module core_tb
	import isa_pkg::*;
	import soc_bus_pkg::*;
();

	localparam int TIMEOUT_CYCLES = 4000;	// Six tests of ~300 cycles with over 2x margin

	logic     clk, reset;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	int       errors, checks, tests, failed_tests;
	int       cycles = 0;
	integer   seed = 32'h0f091801;
	xlen_t    prog [$];	// Program under assembly

	clk_gen clk_gen_inst (
		.clk   (clk),
		.reset (reset)
	);

	core_top core_top_inst (
		.clk     (clk),
		.reset   (reset),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp)
	);

	//////////////////////////////////////////////////////////////////////
	// Instruction assembly

	function automatic xlen_t op_word(logic [6:0] funct7, reg_idx_t rs2, reg_idx_t rs1,
		logic [2:0] funct3, reg_idx_t rd, logic [6:0] opc);
		inst_u w;
		w.r = '{funct7: funct7, rs2: rs2, rs1: rs1, funct3: funct3, rd: rd, opcode: opc};
		return w;
	endfunction

	function automatic xlen_t imm_word(logic [6:0] opc, logic [2:0] funct3, reg_idx_t rd,
		reg_idx_t rs1, logic [11:0] imm);
		inst_u w;
		w.i = '{imm: imm, rs1: rs1, funct3: funct3, rd: rd, opcode: opc};
		return w;
	endfunction

	function automatic xlen_t store_word(reg_idx_t rs2, reg_idx_t rs1, logic [11:0] imm);
		inst_u w;
		w.s = '{imm_hi: imm[11:5], rs2: rs2, rs1: rs1, funct3: 3'b010,
			imm_lo: imm[4:0], opcode: STORE};
		return w;
	endfunction

	function automatic xlen_t upper_word(reg_idx_t rd, logic [19:0] imm);
		inst_u w;
		w.u = '{imm: imm, rd: rd, opcode: LUI};
		return w;
	endfunction

	// LUI plus ADDI with the upper part rounded for the sign-extended low part
	task automatic push_const(input reg_idx_t rd, input xlen_t val);
		xlen_t hi;
		hi = val + 32'h800;
		prog.push_back(upper_word(rd, hi[31:12]));
		prog.push_back(imm_word(OP_IMM, 3'b000, rd, rd, val[11:0]));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Compare tasks

	task automatic compare_word(input string name, input xlen_t got, input xlen_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic compare_rsp(input string name, input apb_rsp_t got, input apb_rsp_t exp);
		checks++;
		if (got.pready !== exp.pready || got.pslverr !== exp.pslverr) begin
			errors++;
			$display("ERROR %0t: %s got pready=%b pslverr=%b expected pready=%b pslverr=%b",
				$time, name, got.pready, got.pslverr, exp.pready, exp.pslverr);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// APB driver with setup then access phase

	task automatic write_apb(input logic [11:0] addr, input xlen_t data, output apb_rsp_t rsp);
		@(posedge clk);
		apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
		@(posedge clk);
		apb_req.penable <= 1'b1;
		@(negedge clk);
		rsp = apb_rsp;	// Mid access phase
		@(posedge clk);
		apb_req <= '0;
	endtask

	task automatic read_apb(input logic [11:0] addr, output apb_rsp_t rsp);
		@(posedge clk);
		apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
		@(posedge clk);
		apb_req.penable <= 1'b1;
		@(negedge clk);
		rsp = apb_rsp;
		@(posedge clk);
		apb_req <= '0;
	endtask

	task automatic write_expect_ok(input logic [11:0] addr, input xlen_t data);
		apb_rsp_t rsp;
		write_apb(addr, data, rsp);
		compare_rsp($sformatf("pslverr write %h", addr), rsp, '{1'b1, 1'b0, 32'h0});
	endtask

	task automatic read_expect(input logic [11:0] addr, input xlen_t exp, input string name);
		apb_rsp_t rsp;
		read_apb(addr, rsp);
		compare_rsp($sformatf("pslverr read %h", addr), rsp, '{1'b1, 1'b0, 32'h0});
		compare_word(name, rsp.prdata, exp);
	endtask

	task automatic load_program();
		for (int i = 0; i < prog.size(); i++)
			write_expect_ok(IMEM_BASE + 12'(4 * i), prog[i]);
	endtask

	task automatic wait_done();
		apb_rsp_t rsp;
		do
			read_apb(STATUS_OFFS, rsp);
		while (rsp.prdata[1] !== 1'b1);
	endtask

	task automatic run_program(input int len);
		write_expect_ok(PROG_LEN_OFFS, 32'(len));
		write_expect_ok(CTRL_OFFS, 32'h1);
		wait_done();
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests++;
		if (errors != errors_before)
			failed_tests++;
		$display("[%s] finished with %0d errors", name, errors - errors_before);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests

	task automatic reset_and_prog_len();
		int    e0;
		xlen_t val;
		e0  = errors;
		read_expect(STATUS_OFFS, 32'h0, "status after reset");
		read_expect(PROG_LEN_OFFS, 32'h0, "prog_len after reset");
		val = $random(seed);
		write_expect_ok(PROG_LEN_OFFS, val);
		read_expect(PROG_LEN_OFFS, {24'h0, val[7:0]}, "prog_len");	// 8-bit count
		report_test("reset_and_prog_len", e0);
	endtask

	task automatic alu_ops();
		int    e0;
		xlen_t a, b;
		xlen_t expv [8];
		e0 = errors;
		a  = $random(seed);
		b  = $random(seed);
		prog.delete();
		push_const(5'd1, a);
		push_const(5'd2, b);
		prog.push_back(op_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, OP));	// ADD
		prog.push_back(op_word(7'h20, 5'd2, 5'd1, 3'b000, 5'd4, OP));	// SUB
		prog.push_back(op_word(7'h00, 5'd2, 5'd1, 3'b111, 5'd5, OP));	// AND
		prog.push_back(op_word(7'h00, 5'd2, 5'd1, 3'b110, 5'd6, OP));	// OR
		prog.push_back(op_word(7'h00, 5'd2, 5'd1, 3'b100, 5'd7, OP));	// XOR
		prog.push_back(op_word(7'h00, 5'd2, 5'd1, 3'b010, 5'd8, OP));	// SLT
		prog.push_back(op_word(7'h00, 5'd2, 5'd1, 3'b001, 5'd9, OP));	// SLL
		prog.push_back(op_word(7'h00, 5'd2, 5'd1, 3'b101, 5'd10, OP));	// SRL
		for (int k = 0; k < 8; k++)
			prog.push_back(store_word(5'(3 + k), 5'd0, 12'(4 * k)));
		expv[0] = a + b;
		expv[1] = a - b;
		expv[2] = a & b;
		expv[3] = a | b;
		expv[4] = a ^ b;
		expv[5] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		expv[6] = a << b[4:0];	// Shift amount is rs2[4:0]
		expv[7] = a >> b[4:0];
		for (int k = 0; k < 8; k++)
			write_expect_ok(DMEM_BASE + 12'(4 * k), ~expv[k]);	// Unlike every result
		load_program();
		run_program(prog.size());
		for (int k = 0; k < 8; k++)
			read_expect(DMEM_BASE + 12'(4 * k), expv[k], $sformatf("dmem[%0d]", k));
		report_test("alu_ops", e0);
	endtask

	task automatic forwarding_chain();
		int    e0;
		xlen_t r11, r12, r13, r14, r15, r16, r17;
		e0 = errors;
		prog.delete();
		prog.push_back(imm_word(OP_IMM, 3'b000, 5'd11, 5'd0, 12'd5));
		prog.push_back(imm_word(OP_IMM, 3'b000, 5'd12, 5'd11, 12'd7));	// Distance 1
		prog.push_back(op_word(7'h00, 5'd11, 5'd12, 3'b000, 5'd13, OP));	// Distances 1 and 2
		prog.push_back(imm_word(OP_IMM, 3'b000, 5'd14, 5'd0, 12'd100));
		prog.push_back(op_word(7'h00, 5'd12, 5'd13, 3'b000, 5'd15, OP));	// Distances 2 and 3
		prog.push_back(op_word(7'h00, 5'd13, 5'd15, 3'b000, 5'd16, OP));
		prog.push_back(op_word(7'h00, 5'd14, 5'd16, 3'b000, 5'd17, OP));	// x14 at distance 3
		prog.push_back(store_word(5'd17, 5'd0, 12'h040));
		// Sequential semantics
		r11 = 32'd5;
		r12 = r11 + 32'd7;
		r13 = r12 + r11;
		r14 = 32'd100;
		r15 = r13 + r12;
		r16 = r15 + r13;
		r17 = r16 + r14;
		load_program();
		run_program(prog.size());
		read_expect(DMEM_BASE + 12'h040, r17, "chain sum");
		report_test("forwarding_chain", e0);
	endtask

	task automatic load_use();
		int    e0;
		xlen_t v;
		e0 = errors;
		v  = $random(seed);
		write_expect_ok(DMEM_BASE + 12'h080, v);	// Word 32
		prog.delete();
		prog.push_back(imm_word(LOAD, 3'b010, 5'd18, 5'd0, 12'h080));
		prog.push_back(imm_word(OP_IMM, 3'b000, 5'd19, 5'd18, 12'h123));	// Uses load at once
		prog.push_back(store_word(5'd19, 5'd0, 12'h084));
		prog.push_back(imm_word(LOAD, 3'b010, 5'd20, 5'd0, 12'h080));
		prog.push_back(op_word(7'h00, 5'd19, 5'd20, 3'b000, 5'd21, OP));	// Stall on rs1
		prog.push_back(store_word(5'd21, 5'd0, 12'h088));
		load_program();
		run_program(prog.size());
		read_expect(DMEM_BASE + 12'h084, v + 32'h123, "load plus imm");
		read_expect(DMEM_BASE + 12'h088, v + v + 32'h123, "load plus reg");
		report_test("load_use", e0);
	endtask

	task automatic zero_register();
		int e0;
		e0 = errors;
		for (int k = 0; k < 3; k++)
			write_expect_ok(DMEM_BASE + 12'h090 + 12'(4 * k), 32'hffff_ffff);
		prog.delete();
		prog.push_back(imm_word(OP_IMM, 3'b000, 5'd23, 5'd0, 12'd77));
		prog.push_back(imm_word(OP_IMM, 3'b000, 5'd0, 5'd0, 12'd55));	// x0 write
		prog.push_back(upper_word(5'd0, 20'habcde));
		prog.push_back(op_word(7'h00, 5'd0, 5'd0, 3'b000, 5'd22, OP));
		prog.push_back(op_word(7'h00, 5'd23, 5'd23, 3'b000, 5'd23, 7'b1111011));	// Unknown
		prog.push_back(store_word(5'd0, 5'd0, 12'h090));
		prog.push_back(store_word(5'd22, 5'd0, 12'h094));
		prog.push_back(store_word(5'd23, 5'd0, 12'h098));
		load_program();
		run_program(prog.size());
		read_expect(DMEM_BASE + 12'h090, 32'h0, "store of x0");
		read_expect(DMEM_BASE + 12'h094, 32'h0, "x0 plus x0");
		read_expect(DMEM_BASE + 12'h098, 32'd77, "x23 after unknown op");
		report_test("zero_register", e0);
	endtask

	task automatic bus_errors();
		int       e0;
		xlen_t    p;
		apb_rsp_t rsp;
		e0 = errors;
		p  = $random(seed);
		write_expect_ok(DMEM_BASE + 12'h0c0, p);	// Word 48
		prog.delete();
		for (int k = 0; k < 24; k++)
			prog.push_back(imm_word(OP_IMM, 3'b000, 5'd0, 5'd0, 12'd0));	// NOP
		load_program();
		write_expect_ok(PROG_LEN_OFFS, 32'd24);
		write_expect_ok(CTRL_OFFS, 32'h1);
		// Core still busy with the NOPs here
		write_apb(DMEM_BASE + 12'h0c0, ~p, rsp);
		compare_rsp("pslverr dmem write mid-run", rsp, '{1'b1, 1'b1, 32'h0});
		write_apb(IMEM_BASE, 32'h0, rsp);
		compare_rsp("pslverr imem write mid-run", rsp, '{1'b1, 1'b1, 32'h0});
		wait_done();
		read_expect(DMEM_BASE + 12'h0c0, p, "dmem[48] after refused write");
		write_apb(12'h00c, 32'h1234, rsp);
		compare_rsp("pslverr unmapped write", rsp, '{1'b1, 1'b1, 32'h0});
		read_apb(12'hc04, rsp);
		compare_rsp("pslverr unmapped read", rsp, '{1'b1, 1'b1, 32'h0});
		report_test("bus_errors", e0);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Sequence and timeout

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Run stopped after %0d cycles without finishing", TIMEOUT_CYCLES);
			$display("Test failed");
			$finish;
		end
	end

	initial begin
		apb_req      = '0;
		errors       = 0;
		checks       = 0;
		tests        = 0;
		failed_tests = 0;
		@(negedge reset);
		@(posedge clk);
		reset_and_prog_len();
		alu_ops();
		forwarding_chain();
		load_use();
		zero_register();
		bus_errors();
		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
			tests, failed_tests, checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== vlog.f ====
design/isa_pkg.sv
design/soc_bus_pkg.sv
design/ctrl_regs.sv
design/inst_decoder.sv
design/core_pipeline.sv
design/data_mem.sv
design/core_top.sv
verif/clk_gen.sv
verif/core_sva.sv
verif/core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build with Verilator, run, and pass only if the testbench reports a pass
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module core_tb -f vlog.f -o core_tb_sim \
	&& ./obj_dir/core_tb_sim | tee /dev/stderr | grep -x "Test passed" > /dev/null \
	|| exit 1
